//--- game_pkg.sv
`default_nettype none

package game_pkg;

	localparam int N_CELLS   = 16;
	localparam int N_LINES   = 10;
	localparam int WIN_SCORE = 1000;

	localparam logic signed [15:0] SCORE_MAX = 16'sd32767;
	localparam logic signed [15:0] SCORE_MIN = -16'sd32767;

	typedef enum logic [1:0] {
		CELL_EMPTY = 2'd0,
		CELL_OWN   = 2'd1,
		CELL_OPP   = 2'd2
	} cell_t;

	// Cell 0 in the low bits, row-major
	typedef cell_t [N_CELLS-1:0] board_t;

	typedef logic [3:0] coord_t;

	typedef logic signed [15:0] score_t;

	// ~~~~~~~~~~~~~~~~~~~~
	// Scored lines: rows, columns, then the two diagonals
	// ~~~~~~~~~~~~~~~~~~~~
	localparam int LINE_CELLS [N_LINES][4] = '{
		'{ 0,  1,  2,  3},
		'{ 4,  5,  6,  7},
		'{ 8,  9, 10, 11},
		'{12, 13, 14, 15},
		'{ 0,  4,  8, 12},
		'{ 1,  5,  9, 13},
		'{ 2,  6, 10, 14},
		'{ 3,  7, 11, 15},
		'{ 0,  5, 10, 15},
		'{ 3,  6,  9, 12}
	};

endpackage

`default_nettype wire

//--- search_pkg.sv
`default_nettype none

package search_pkg;

	localparam int MAX_DEPTH = 4;

	typedef logic [2:0] depth_t;

	// 0 is the search, 1 is the host
	typedef logic evtag_t;

	typedef struct packed {
		game_pkg::board_t board;
	} eval_req_t;

	typedef struct packed {
		game_pkg::score_t score;
	} eval_rsp_t;

	typedef struct packed {
		game_pkg::coord_t move;
		game_pkg::score_t score;
		logic             no_move;
	} search_res_t;

	// ~~~~~~~~~~~~~~~~~~~~
	// Register map
	// ~~~~~~~~~~~~~~~~~~~~
	localparam logic [4:0] REG_CTRL        = 5'h00;
	localparam logic [4:0] REG_BOARD       = 5'h04;
	localparam logic [4:0] REG_STATUS      = 5'h08;
	localparam logic [4:0] REG_RESULT      = 5'h0C;
	localparam logic [4:0] REG_EVAL_BOARD  = 5'h10;
	localparam logic [4:0] REG_EVAL_RESULT = 5'h14;

endpackage

`default_nettype wire

//--- axil_regs.sv
`timescale 1ns/1ps
`default_nettype none

module axil_regs (
	input  wire                      i_clk,
	input  wire                      i_rst_n,
	input  wire  [4:0]               i_awaddr,
	input  wire                      i_awvalid,
	output logic                     o_awready,
	input  wire  [31:0]              i_wdata,
	input  wire                      i_wvalid,
	output logic                     o_wready,
	output logic [1:0]               o_bresp,
	output logic                     o_bvalid,
	input  wire                      i_bready,
	input  wire  [4:0]               i_araddr,
	input  wire                      i_arvalid,
	output logic                     o_arready,
	output logic [31:0]              o_rdata,
	output logic [1:0]               o_rresp,
	output logic                     o_rvalid,
	input  wire                      i_rready,
	output logic                     o_start,
	output game_pkg::board_t         o_board,
	output search_pkg::depth_t       o_depth,
	input  wire                      i_done,
	input  search_pkg::search_res_t  i_result,
	output search_pkg::eval_req_t    o_eval_req,
	output logic                     o_eval_valid,
	input  wire                      i_eval_ready,
	input  search_pkg::eval_rsp_t    i_eval_rsp,
	input  wire                      i_eval_rsp_valid
);
	import search_pkg::*;

	logic        wr_en;
	logic        rd_en;
	logic        busy;
	logic        done;
	logic        eval_done;
	search_res_t result_r;
	game_pkg::score_t eval_score;
	logic [31:0] rd_mux;

	assign wr_en   = o_awready & i_awvalid & o_wready & i_wvalid;
	assign rd_en   = o_arready & i_arvalid;
	assign o_bresp = 2'b00;
	assign o_rresp = 2'b00;

	// ~~~~~~~~~~~~~~~~~~~~
	// Bus handshakes
	// ~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_awready <= 1'b0;
			o_wready  <= 1'b0;
			o_bvalid  <= 1'b0;
			o_arready <= 1'b0;
			o_rvalid  <= 1'b0;
		end else begin
			o_awready <= i_awvalid & i_wvalid & ~o_awready & ~o_bvalid;
			o_wready  <= i_awvalid & i_wvalid & ~o_awready & ~o_bvalid;
			if (wr_en)
				o_bvalid <= 1'b1;
			else if (i_bready)
				o_bvalid <= 1'b0;
			o_arready <= i_arvalid & ~o_arready & ~o_rvalid;
			if (rd_en)
				o_rvalid <= 1'b1;
			else if (i_rready)
				o_rvalid <= 1'b0;
		end
	end

	always_comb begin
		rd_mux = '0;
		case (i_araddr)
			REG_CTRL:        rd_mux = {28'd0, o_depth, 1'b0};
			REG_BOARD:       rd_mux = o_board;
			REG_STATUS:      rd_mux = {28'd0, eval_done, result_r.no_move, done, busy};
			REG_RESULT:      rd_mux = {result_r.score, 12'd0, result_r.move};
			REG_EVAL_BOARD:  rd_mux = o_eval_req.board;
			REG_EVAL_RESULT: rd_mux = {16'd0, eval_score};
			default:         rd_mux = '0;
		endcase
	end

	always_ff @(posedge i_clk) begin
		if (rd_en)
			o_rdata <= rd_mux;
	end

	// ~~~~~~~~~~~~~~~~~~~~
	// Search control
	// ~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_start  <= 1'b0;
			o_depth  <= 3'd1;
			o_board  <= '0;
			busy     <= 1'b0;
			done     <= 1'b0;
			result_r <= '0;
		end else begin
			o_start <= 1'b0;
			if (wr_en && i_awaddr == REG_BOARD)
				o_board <= i_wdata;
			if (wr_en && i_awaddr == REG_CTRL && i_wdata[0] && !busy) begin
				o_start <= 1'b1;
				o_depth <= i_wdata[3:1];
				busy    <= 1'b1;
				done    <= 1'b0;
			end
			if (i_done) begin
				busy     <= 1'b0;
				done     <= 1'b1;
				result_r <= i_result;
			end
		end
	end

	// Host evaluation request held until the arbiter grants it
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_eval_valid <= 1'b0;
			eval_done    <= 1'b0;
		end else begin
			if (wr_en && i_awaddr == REG_EVAL_BOARD) begin
				o_eval_valid <= 1'b1;
				eval_done    <= 1'b0;
			end else if (i_eval_ready) begin
				o_eval_valid <= 1'b0;
			end
			if (i_eval_rsp_valid)
				eval_done <= 1'b1;
		end
	end

	always_ff @(posedge i_clk) begin
		if (wr_en && i_awaddr == REG_EVAL_BOARD)
			o_eval_req.board <= i_wdata;
		if (i_eval_rsp_valid)
			eval_score <= i_eval_rsp.score;
	end

	a_eval_hold: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		o_eval_valid && !i_eval_ready |=> o_eval_valid && $stable(o_eval_req));

endmodule

`default_nettype wire

//--- board_eval.sv
`timescale 1ns/1ps
`default_nettype none

module board_eval (
	input  wire                    i_clk,
	input  wire                    i_rst_n,
	input  search_pkg::eval_req_t  i_req,
	input  wire                    i_valid,
	output search_pkg::eval_rsp_t  o_rsp,
	output logic                   o_valid
);
	import game_pkg::*;

	logic [2:0] own_cnt [N_LINES];
	logic [2:0] opp_cnt [N_LINES];
	logic [2:0] own_q   [N_LINES];
	logic [2:0] opp_q   [N_LINES];
	logic       valid_q;
	score_t     sum;

	// Stage 1 piece counts per line
	always_comb begin
		for (int l = 0; l < N_LINES; l++) begin
			own_cnt[l] = '0;
			opp_cnt[l] = '0;
			for (int c = 0; c < 4; c++) begin
				if (i_req.board[LINE_CELLS[l][c]] == CELL_OWN)
					own_cnt[l] = own_cnt[l] + 3'd1;
				if (i_req.board[LINE_CELLS[l][c]] == CELL_OPP)
					opp_cnt[l] = opp_cnt[l] + 3'd1;
			end
		end
	end

	always_ff @(posedge i_clk) begin
		own_q <= own_cnt;
		opp_q <= opp_cnt;
	end

	// Stage 2 line terms where mixed lines score nothing
	always_comb begin
		sum = '0;
		for (int l = 0; l < N_LINES; l++) begin
			if (opp_q[l] == 3'd0 && own_q[l] == 3'd4)
				sum = sum + score_t'(WIN_SCORE);
			else if (opp_q[l] == 3'd0)
				sum = sum + score_t'(own_q[l]) * score_t'(own_q[l]);
			else if (own_q[l] == 3'd0 && opp_q[l] == 3'd4)
				sum = sum - score_t'(WIN_SCORE);
			else if (own_q[l] == 3'd0)
				sum = sum - score_t'(opp_q[l]) * score_t'(opp_q[l]);
		end
	end

	always_ff @(posedge i_clk) begin
		o_rsp.score <= sum;
	end

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			valid_q <= 1'b0;
			o_valid <= 1'b0;
		end else begin
			valid_q <= i_valid;
			o_valid <= valid_q;
		end
	end

endmodule

`default_nettype wire

//--- eval_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module eval_arbiter #(
	parameter type REQ_T = logic,
	parameter type RSP_T = logic
) (
	input  wire   i_clk,
	input  wire   i_rst_n,
	input  REQ_T  i_req [2],
	input  wire   i_req_valid [2],
	output logic  o_req_ready [2],
	output REQ_T  o_req,
	output logic  o_req_valid,
	input  RSP_T  i_rsp,
	input  wire   i_rsp_valid,
	output RSP_T  o_rsp,
	output logic  o_rsp_valid [2]
);
	import search_pkg::*;

	evtag_t gnt;
	evtag_t last_r;
	evtag_t tag_q [2];
	logic   vld_q [2];

	// Round robin: on contention the peer not served last wins
	always_comb begin
		if (i_req_valid[0] && i_req_valid[1])
			gnt = ~last_r;
		else
			gnt = i_req_valid[1];
	end

	assign o_req_valid    = i_req_valid[0] | i_req_valid[1];
	assign o_req          = i_req[gnt];
	assign o_req_ready[0] = i_req_valid[0] & (gnt == 1'b0);
	assign o_req_ready[1] = i_req_valid[1] & (gnt == 1'b1);

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			last_r   <= 1'b1;
			tag_q[0] <= 1'b0;
			tag_q[1] <= 1'b0;
			vld_q[0] <= 1'b0;
			vld_q[1] <= 1'b0;
		end else begin
			if (o_req_valid)
				last_r <= gnt;
			// Two stages to line up with the evaluator
			tag_q[0] <= gnt;
			vld_q[0] <= o_req_valid;
			tag_q[1] <= tag_q[0];
			vld_q[1] <= vld_q[0];
		end
	end

	assign o_rsp          = i_rsp;
	assign o_rsp_valid[0] = i_rsp_valid & vld_q[1] & (tag_q[1] == 1'b0);
	assign o_rsp_valid[1] = i_rsp_valid & vld_q[1] & (tag_q[1] == 1'b1);

	a_one_grant: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		$onehot0({o_req_ready[1], o_req_ready[0]}));

	a_rsp_aligned: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		i_rsp_valid == vld_q[1]);

endmodule

`default_nettype wire

//--- minmax_level.sv
`timescale 1ns/1ps
`default_nettype none

module minmax_level (
	input  wire               i_clk,
	input  wire               i_rst_n,
	input  wire               i_start,
	input  game_pkg::board_t  i_board,
	input  game_pkg::score_t  i_bound,
	input  wire               i_maximize,
	input  wire               i_leaf,
	input  wire               i_next,
	input  game_pkg::score_t  i_point,
	output logic              o_start,
	output game_pkg::board_t  o_board,
	output game_pkg::score_t  o_bound,
	output logic              o_finish,
	output game_pkg::score_t  o_point,
	output game_pkg::coord_t  o_move,
	output logic              o_no_move
);
	import game_pkg::*;

	typedef enum logic [1:0] {S_IDLE, S_SCAN, S_WAIT} state_t;

	state_t state;
	board_t board_r;
	score_t bound_r;
	score_t best;
	score_t new_best;
	logic   max_r;
	logic   leaf_r;
	logic   found;
	logic   pass_r;
	logic   better;
	logic   cut;
	logic [4:0] idx;

	always_comb begin
		better   = max_r ? (i_point > best) : (i_point < best);
		new_best = better ? i_point : best;
		cut      = max_r ? (new_best >= bound_r) : (new_best <= bound_r);
	end

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state    <= S_IDLE;
			idx      <= '0;
			found    <= 1'b0;
			pass_r   <= 1'b0;
			max_r    <= 1'b0;
			leaf_r   <= 1'b0;
			o_start  <= 1'b0;
			o_finish <= 1'b0;
		end else begin
			o_start  <= 1'b0;
			o_finish <= 1'b0;
			case (state)
				S_IDLE: begin
					if (i_start) begin
						max_r  <= i_maximize;
						leaf_r <= i_leaf;
						idx    <= '0;
						found  <= 1'b0;
						pass_r <= 1'b0;
						state  <= S_SCAN;
					end
				end
				S_SCAN: begin
					if (idx[4]) begin
						// No empty cell: hand the board down unchanged once
						if (!found && !pass_r) begin
							pass_r  <= 1'b1;
							o_start <= 1'b1;
							state   <= S_WAIT;
						end else begin
							o_finish <= 1'b1;
							state    <= S_IDLE;
						end
					end else if (board_r[idx[3:0]] == CELL_EMPTY) begin
						o_start <= 1'b1;
						state   <= S_WAIT;
					end else begin
						idx <= idx + 5'd1;
					end
				end
				S_WAIT: begin
					if (i_next) begin
						if (pass_r) begin
							o_finish <= 1'b1;
							state    <= S_IDLE;
						end else begin
							found <= 1'b1;
							if (cut) begin
								o_finish <= 1'b1;
								state    <= S_IDLE;
							end else begin
								idx   <= idx + 5'd1;
								state <= S_SCAN;
							end
						end
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	// Payload registers
	always_ff @(posedge i_clk) begin
		if (state == S_IDLE && i_start) begin
			board_r <= i_board;
			bound_r <= i_bound;
			best    <= i_maximize ? SCORE_MIN : SCORE_MAX;
			o_move  <= '0;
		end
		if (state == S_SCAN) begin
			o_board <= board_r;
			if (!idx[4])
				o_board[idx[3:0]] <= max_r ? CELL_OWN : CELL_OPP;
		end
		if (state == S_WAIT && i_next) begin
			if (pass_r) begin
				best <= i_point;
			end else if (better) begin
				best   <= i_point;
				o_move <= idx[3:0];
			end
		end
	end

	assign o_point   = best;
	assign o_no_move = ~found;
	// Evaluations below a leaf take no bound
	assign o_bound   = leaf_r ? '0 : best;

endmodule

`default_nettype wire

//--- dfs_search.sv
`timescale 1ns/1ps
`default_nettype none

module dfs_search (
	input  wire                      i_clk,
	input  wire                      i_rst_n,
	input  wire                      i_start,
	input  search_pkg::depth_t       i_depth,
	input  game_pkg::board_t         i_board,
	output logic                     o_done,
	output search_pkg::search_res_t  o_result,
	output search_pkg::eval_req_t    o_eval_req,
	output logic                     o_eval_valid,
	input  wire                      i_eval_ready,
	input  search_pkg::eval_rsp_t    i_eval_rsp,
	input  wire                      i_eval_rsp_valid
);
	import game_pkg::*;
	import search_pkg::*;

	depth_t depth_eff;
	logic [1:0] leaf_idx;
	logic   leaf    [MAX_DEPTH];
	logic   lvl_in  [MAX_DEPTH];
	logic   nxt     [MAX_DEPTH];
	score_t nxt_pt  [MAX_DEPTH];
	logic   start_w [MAX_DEPTH];
	board_t board_w [MAX_DEPTH];
	score_t bound_w [MAX_DEPTH];
	logic   fin_w   [MAX_DEPTH+1];
	score_t point_w [MAX_DEPTH+1];
	coord_t move_w  [MAX_DEPTH];
	logic   nomv_w  [MAX_DEPTH];

	// Depth outside 1..4 is clamped
	assign depth_eff = (i_depth == 3'd0) ? 3'd1 :
	                   (i_depth > 3'(MAX_DEPTH)) ? 3'(MAX_DEPTH) : i_depth;
	assign leaf_idx  = 2'(depth_eff - 3'd1);

	assign fin_w[MAX_DEPTH]   = 1'b0;
	assign point_w[MAX_DEPTH] = '0;

	for (genvar l = 0; l < MAX_DEPTH; l++) begin : g_lvl
		assign leaf[l] = (leaf_idx == 2'(l));
		if (l == 0) begin : g_root
			assign lvl_in[l] = i_start;
		end else begin : g_child
			assign lvl_in[l] = start_w[l-1] & ~leaf[l-1];
		end
		assign nxt[l]    = leaf[l] ? i_eval_rsp_valid : fin_w[l+1];
		assign nxt_pt[l] = leaf[l] ? i_eval_rsp.score : point_w[l+1];

		minmax_level level_i (
			.i_clk      (i_clk),
			.i_rst_n    (i_rst_n),
			.i_start    (lvl_in[l]),
			.i_board    ((l == 0) ? i_board : board_w[(l == 0) ? 0 : l-1]),
			.i_bound    ((l == 0) ? SCORE_MAX : bound_w[(l == 0) ? 0 : l-1]),
			.i_maximize ((l % 2) == 0),
			.i_leaf     (leaf[l]),
			.i_next     (nxt[l]),
			.i_point    (nxt_pt[l]),
			.o_start    (start_w[l]),
			.o_board    (board_w[l]),
			.o_bound    (bound_w[l]),
			.o_finish   (fin_w[l]),
			.o_point    (point_w[l]),
			.o_move     (move_w[l]),
			.o_no_move  (nomv_w[l])
		);
	end

	// Leaf request held until the arbiter takes it
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n)
			o_eval_valid <= 1'b0;
		else if (start_w[leaf_idx])
			o_eval_valid <= 1'b1;
		else if (i_eval_ready)
			o_eval_valid <= 1'b0;
	end

	always_ff @(posedge i_clk) begin
		if (start_w[leaf_idx])
			o_eval_req.board <= board_w[leaf_idx];
	end

	assign o_done           = fin_w[0];
	assign o_result.move    = move_w[0];
	assign o_result.score   = point_w[0];
	assign o_result.no_move = nomv_w[0];

endmodule

`default_nettype wire

//--- minmax_top.sv
`timescale 1ns/1ps
`default_nettype none

module minmax_top (
	input  wire         i_clk,
	input  wire         i_rst_n,
	input  wire  [4:0]  i_awaddr,
	input  wire         i_awvalid,
	output logic        o_awready,
	input  wire  [31:0] i_wdata,
	input  wire         i_wvalid,
	output logic        o_wready,
	output logic [1:0]  o_bresp,
	output logic        o_bvalid,
	input  wire         i_bready,
	input  wire  [4:0]  i_araddr,
	input  wire         i_arvalid,
	output logic        o_arready,
	output logic [31:0] o_rdata,
	output logic [1:0]  o_rresp,
	output logic        o_rvalid,
	input  wire         i_rready
);
	import game_pkg::*;
	import search_pkg::*;

	logic        start;
	logic        done;
	board_t      board;
	depth_t      depth;
	search_res_t result;
	eval_req_t   req    [2];
	logic        req_vld [2];
	logic        req_rdy [2];
	eval_rsp_t   rsp;
	logic        rsp_vld [2];
	eval_req_t   ev_req;
	logic        ev_req_vld;
	eval_rsp_t   ev_rsp;
	logic        ev_rsp_vld;

	// Port 0 is the search, port 1 the host
	axil_regs regs_i (
		.i_clk (i_clk), .i_rst_n (i_rst_n),
		.i_awaddr (i_awaddr), .i_awvalid (i_awvalid), .o_awready (o_awready),
		.i_wdata (i_wdata), .i_wvalid (i_wvalid), .o_wready (o_wready),
		.o_bresp (o_bresp), .o_bvalid (o_bvalid), .i_bready (i_bready),
		.i_araddr (i_araddr), .i_arvalid (i_arvalid), .o_arready (o_arready),
		.o_rdata (o_rdata), .o_rresp (o_rresp), .o_rvalid (o_rvalid), .i_rready (i_rready),
		.o_start (start), .o_board (board), .o_depth (depth),
		.i_done (done), .i_result (result),
		.o_eval_req (req[1]), .o_eval_valid (req_vld[1]), .i_eval_ready (req_rdy[1]),
		.i_eval_rsp (rsp), .i_eval_rsp_valid (rsp_vld[1])
	);

	dfs_search search_i (
		.i_clk (i_clk), .i_rst_n (i_rst_n),
		.i_start (start), .i_depth (depth), .i_board (board),
		.o_done (done), .o_result (result),
		.o_eval_req (req[0]), .o_eval_valid (req_vld[0]), .i_eval_ready (req_rdy[0]),
		.i_eval_rsp (rsp), .i_eval_rsp_valid (rsp_vld[0])
	);

	eval_arbiter #(.REQ_T (eval_req_t), .RSP_T (eval_rsp_t)) arb_i (
		.i_clk (i_clk), .i_rst_n (i_rst_n),
		.i_req (req), .i_req_valid (req_vld), .o_req_ready (req_rdy),
		.o_req (ev_req), .o_req_valid (ev_req_vld),
		.i_rsp (ev_rsp), .i_rsp_valid (ev_rsp_vld),
		.o_rsp (rsp), .o_rsp_valid (rsp_vld)
	);

	board_eval eval_i (
		.i_clk (i_clk), .i_rst_n (i_rst_n),
		.i_req (ev_req), .i_valid (ev_req_vld),
		.o_rsp (ev_rsp), .o_valid (ev_rsp_vld)
	);

endmodule

`default_nettype wire

//--- tb_minmax_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_minmax_top;
	import search_pkg::*;

	localparam int TIMEOUT_CYCLES = 1000;
	localparam int MAX_POLLS      = 100000;

	logic        clk;
	logic        rst_n;
	logic [4:0]  awaddr;
	logic        awvalid;
	logic        awready;
	logic [31:0] wdata;
	logic        wvalid;
	logic        wready;
	logic [1:0]  bresp;
	logic        bvalid;
	logic        bready;
	logic [4:0]  araddr;
	logic        arvalid;
	logic        arready;
	logic [31:0] rdata;
	logic [1:0]  rresp;
	logic        rvalid;
	logic        rready;

	logic [31:0] rng;
	int          check_errs;
	int          timeout_errs;
	logic        chk_en;
	logic        idle_chk;
	logic [31:0] exp_data;
	logic [31:0] exp_mask;
	string       chk_name;
	logic [31:0] brd;
	logic [31:0] ev_brd;

	minmax_top dut_i (
		.i_clk (clk), .i_rst_n (rst_n),
		.i_awaddr (awaddr), .i_awvalid (awvalid), .o_awready (awready),
		.i_wdata (wdata), .i_wvalid (wvalid), .o_wready (wready),
		.o_bresp (bresp), .o_bvalid (bvalid), .i_bready (bready),
		.i_araddr (araddr), .i_arvalid (arvalid), .o_arready (arready),
		.o_rdata (rdata), .o_rresp (rresp), .o_rvalid (rvalid), .i_rready (rready)
	);

	always #4 clk = ~clk;

	// ~~~~~~~~~~~~~~~~~~~~
	// Checks
	// ~~~~~~~~~~~~~~~~~~~~
	a_read_value: assert property (@(posedge clk)
		(chk_en && rvalid && rready) |-> ((rdata & exp_mask) == exp_data))
		else begin
			check_errs++;
			$display("CHECK FAILED at %0t: %s, expected %h, got %h",
				$time, chk_name, exp_data, rdata & exp_mask);
		end

	a_idle_outputs: assert property (@(posedge clk)
		idle_chk |-> !(awready || wready || bvalid || arready || rvalid))
		else begin
			check_errs++;
			$display("CHECK FAILED at %0t: bus outputs active right after reset", $time);
		end

	a_resp_okay: assert property (@(posedge clk) disable iff (!rst_n)
		(bvalid || rvalid) |-> (bresp == 2'b00 && rresp == 2'b00))
		else begin
			check_errs++;
			$display("CHECK FAILED at %0t: bus response is not OKAY", $time);
		end

	// ~~~~~~~~~~~~~~~~~~~~
	// Reference model
	// ~~~~~~~~~~~~~~~~~~~~
	function automatic logic [31:0] next_rand();
		rng = rng ^ (rng << 13);
		rng = rng ^ (rng >> 17);
		rng = rng ^ (rng << 5);
		return rng;
	endfunction

	// Code 3 is not a legal cell, it becomes empty
	function automatic logic [31:0] random_board();
		logic [31:0] r;
		logic [31:0] b;
		r = next_rand();
		for (int c = 0; c < 16; c++)
			b[2*c +: 2] = (r[2*c +: 2] == 2'd3) ? 2'd0 : r[2*c +: 2];
		return b;
	endfunction

	function automatic logic [31:0] full_board();
		logic [31:0] r;
		logic [31:0] b;
		r = next_rand();
		for (int c = 0; c < 16; c++)
			b[2*c +: 2] = r[c] ? 2'd1 : 2'd2;
		return b;
	endfunction

	function automatic int line_score(input int own, input int opp);
		if (opp == 0 && own == 4)
			return 1000;
		if (opp == 0)
			return own * own;
		if (own == 0 && opp == 4)
			return -1000;
		if (own == 0)
			return -(opp * opp);
		return 0;
	endfunction

	function automatic int ref_eval(input logic [31:0] b);
		int total;
		int own;
		int opp;
		int idx;
		total = 0;
		for (int l = 0; l < 10; l++) begin
			own = 0;
			opp = 0;
			for (int k = 0; k < 4; k++) begin
				if (l < 4)
					idx = 4 * l + k;
				else if (l < 8)
					idx = 4 * k + (l - 4);
				else if (l == 8)
					idx = 5 * k;
				else
					idx = 3 + 3 * k;
				if (b[2*idx +: 2] == 2'd1)
					own++;
				else if (b[2*idx +: 2] == 2'd2)
					opp++;
			end
			total += line_score(own, opp);
		end
		return total;
	endfunction

	// Plain minimax, a side with no empty cell passes
	function automatic int ref_minimax(input logic [31:0] b, input int ply, input int depth,
			output logic [3:0] move);
		logic [31:0] nb;
		logic [3:0]  sub_move;
		int          best;
		int          val;
		logic        found;
		logic        maximize;
		maximize = (ply % 2 == 0);
		best     = maximize ? -32767 : 32767;
		move     = 4'd0;
		found    = 1'b0;
		for (int c = 0; c < 16; c++) begin
			if (b[2*c +: 2] == 2'd0) begin
				nb = b;
				nb[2*c +: 2] = maximize ? 2'd1 : 2'd2;
				if (ply == depth - 1)
					val = ref_eval(nb);
				else
					val = ref_minimax(nb, ply + 1, depth, sub_move);
				if (maximize ? (val > best) : (val < best)) begin
					best = val;
					move = 4'(c);
				end
				found = 1'b1;
			end
		end
		if (!found) begin
			if (ply == depth - 1)
				best = ref_eval(b);
			else
				best = ref_minimax(b, ply + 1, depth, sub_move);
		end
		return best;
	endfunction

	// ~~~~~~~~~~~~~~~~~~~~
	// Bus tasks
	// ~~~~~~~~~~~~~~~~~~~~
	task automatic axi_write(input logic [4:0] addr, input logic [31:0] data);
		int waited;
		@(negedge clk);
		awaddr  = addr;
		wdata   = data;
		awvalid = 1'b1;
		wvalid  = 1'b1;
		waited  = 0;
		while (!awready && waited < TIMEOUT_CYCLES) begin
			@(negedge clk);
			waited++;
		end
		if (!awready) begin
			timeout_errs++;
			$display("Timeout: write to address %h was never accepted", addr);
		end
		@(negedge clk);
		awvalid = 1'b0;
		wvalid  = 1'b0;
		// Some back-pressure on the write response
		repeat (next_rand() % 3) @(negedge clk);
		bready = 1'b1;
		waited = 0;
		while (!bvalid && waited < TIMEOUT_CYCLES) begin
			@(negedge clk);
			waited++;
		end
		if (!bvalid) begin
			timeout_errs++;
			$display("Timeout: no write response for address %h", addr);
		end
		@(negedge clk);
		bready = 1'b0;
	endtask

	task automatic axi_read(input logic [4:0] addr, output logic [31:0] data);
		int waited;
		@(negedge clk);
		araddr  = addr;
		arvalid = 1'b1;
		waited  = 0;
		while (!arready && waited < TIMEOUT_CYCLES) begin
			@(negedge clk);
			waited++;
		end
		if (!arready) begin
			timeout_errs++;
			$display("Timeout: read of address %h was never accepted", addr);
		end
		@(negedge clk);
		arvalid = 1'b0;
		repeat (next_rand() % 3) @(negedge clk);
		waited = 0;
		while (!rvalid && waited < TIMEOUT_CYCLES) begin
			@(negedge clk);
			waited++;
		end
		if (!rvalid) begin
			timeout_errs++;
			$display("Timeout: no read data for address %h", addr);
		end
		data   = rdata;
		rready = 1'b1;
		@(negedge clk);
		rready = 1'b0;
	endtask

	task automatic check_read(input logic [4:0] addr, input logic [31:0] expected,
			input logic [31:0] mask, input string name);
		logic [31:0] got;
		exp_data = expected & mask;
		exp_mask = mask;
		chk_name = name;
		chk_en   = 1'b1;
		axi_read(addr, got);
		chk_en   = 1'b0;
	endtask

	task automatic wait_status_bit(input int bit_idx, input string what);
		logic [31:0] st;
		int          polls;
		polls = 0;
		axi_read(REG_STATUS, st);
		while (!st[bit_idx] && polls < MAX_POLLS) begin
			polls++;
			axi_read(REG_STATUS, st);
		end
		if (!st[bit_idx]) begin
			timeout_errs++;
			$display("Timeout: STATUS never showed %s", what);
		end
	endtask

	// ~~~~~~~~~~~~~~~~~~~~
	// Scenarios
	// ~~~~~~~~~~~~~~~~~~~~
	task automatic host_eval(input logic [31:0] b);
		int score;
		score = ref_eval(b);
		axi_write(REG_EVAL_BOARD, b);
		wait_status_bit(3, "eval_valid");
		check_read(REG_EVAL_RESULT, {16'd0, score[15:0]}, 32'hffff_ffff, "host evaluation");
	endtask

	task automatic start_search(input logic [31:0] b, input int depth);
		logic [2:0] d;
		d = 3'(depth);
		axi_write(REG_BOARD, b);
		axi_write(REG_CTRL, {28'd0, d, 1'b1});
	endtask

	task automatic finish_search(input logic [31:0] b, input int depth);
		logic [3:0] move;
		int         score;
		logic       no_move;
		score   = ref_minimax(b, 0, depth, move);
		no_move = 1'b1;
		for (int c = 0; c < 16; c++)
			if (b[2*c +: 2] == 2'd0)
				no_move = 1'b0;
		wait_status_bit(1, "done");
		check_read(REG_STATUS, {29'd0, no_move, 2'b10}, 32'h7, "status after search");
		check_read(REG_RESULT, {score[15:0], 12'd0, move}, 32'hffff_ffff, "search result");
	endtask

	task automatic run_search(input logic [31:0] b, input int depth);
		start_search(b, depth);
		finish_search(b, depth);
	endtask

	initial begin
		rng          = 32'he4ac;
		clk          = 1'b0;
		rst_n        = 1'b0;
		awaddr       = '0;
		awvalid      = 1'b0;
		wdata        = '0;
		wvalid       = 1'b0;
		bready       = 1'b0;
		araddr       = '0;
		arvalid      = 1'b0;
		rready       = 1'b0;
		chk_en       = 1'b0;
		idle_chk     = 1'b0;
		exp_data     = '0;
		exp_mask     = '0;
		chk_name     = "";
		check_errs   = 0;
		timeout_errs = 0;

		repeat (2) @(negedge clk);
		idle_chk = 1'b1;
		repeat (8) @(negedge clk);
		rst_n = 1'b1;
		repeat (3) @(negedge clk);
		idle_chk = 1'b0;
		check_read(REG_STATUS, 32'd0, 32'hffff_ffff, "STATUS after reset");

		// Fixed boards with full lines of either side
		host_eval(32'h0000_0000);
		host_eval(32'h0000_0055);
		host_eval(32'h0808_0808);
		host_eval(32'h5555_5555);
		host_eval(32'haaaa_aaaa);
		repeat (6) host_eval(random_board());

		for (int d = 1; d <= 4; d++)
			repeat (2) run_search(random_board(), d);

		run_search(full_board(), 1);
		run_search(full_board(), 3);

		// Host evaluation competing with the leaf level
		brd    = random_board() & 32'h0000_ffff;
		ev_brd = random_board();
		start_search(brd, 3);
		host_eval(ev_brd);
		finish_search(brd, 3);

		// Second start while busy must be dropped
		brd = random_board() & 32'h0000_ffff;
		start_search(brd, 4);
		axi_write(REG_CTRL, {28'd0, 3'd1, 1'b1});
		check_read(REG_STATUS, 32'h1, 32'h3, "busy after ignored start");
		check_read(REG_CTRL, 32'h8, 32'he, "depth after ignored start");
		finish_search(brd, 4);

		$display("Error counts: %0d check failures, %0d timeouts", check_errs, timeout_errs);
		if (check_errs == 0 && timeout_errs == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule

`default_nettype wire

//--- filelist.f
game_pkg.sv
search_pkg.sv
axil_regs.sv
board_eval.sv
eval_arbiter.sv
minmax_level.sv
dfs_search.sv
minmax_top.sv
tb_minmax_top.sv

//--- Bender.yml
package:
  name: minmax_accel

sources:
  - game_pkg.sv
  - search_pkg.sv
  - axil_regs.sv
  - board_eval.sv
  - eval_arbiter.sv
  - minmax_level.sv
  - dfs_search.sv
  - minmax_top.sv
  - target: test
    files:
      - tb_minmax_top.sv
